// File: Makefile
BIN = obj_dir/Vmem_stage3_tb

.PHONY: all run check clean

all: check

# rebuilt only when the file list, an RTL source or a bench source changes.
$(BIN): mem_stage3.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module mem_stage3_tb \
		-f mem_stage3.f -o Vmem_stage3_tb

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log

check: run
	@if grep -q "test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "test passed" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen
#(
	parameter real PERIOD_NS = 4.0,
	parameter int  RESET_CYCLES = 5
)
(
	output logic clk,
	output logic resetb
);
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

	initial
	begin
		resetb = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		resetb = 1'b1;  // released halfway between rising edges.
	end

endmodule

// File: bench/mem_stage3_assertions.sv
`timescale 1ns/1ps

module mem_stage3_assertions
(
	input logic                    clk,
	input logic                    resetb,
	input gpu_mem_pkg::miss_info_t miss_i,
	input gpu_mem_pkg::mem_wb_t    wb_i,
	input gpu_mem_pkg::mshr_fb_t   fb_i
);
	logic miss_seen;

	// set once any miss has been reported since reset.
	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			miss_seen <= 1'b0;
		else if (miss_i.valid && !miss_i.hit)
			miss_seen <= 1'b1;
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!resetb)
		!(wb_i.reg_write && wb_i.write_fb_valid))
		else $error("load and store completion raised in the same cycle");

	a_rdata_idle: assert property (@(posedge clk) disable iff (!resetb)
		!wb_i.reg_write |-> wb_i.rdata == '0)
		else $error("rdata is not zero without a load completion");

	a_reset_quiet: assert property (@(posedge clk)
		!resetb |-> !(wb_i.reg_write || wb_i.write_fb_valid || fb_i.valid))
		else $error("an output strobe is high during reset");

	a_fb_after_miss: assert property (@(posedge clk) disable iff (!resetb)
		$rose(fb_i.valid) |-> miss_seen)
		else $error("MSHR feedback rose without any earlier miss");

endmodule

// File: bench/mem_stage3_tb.sv
`timescale 1ns/1ps
`include "gpu_mem_defines.svh"

module mem_stage3_tb;
	localparam int LINES = `MEM_SIZE + `SHMEM_SIZE;
	localparam int FIO_OPS = 40;
	localparam int LOADS = 40;
	localparam int STORES = 30;
	localparam int MIX_OPS = 200;
	localparam int SPACED_MISSES = 8;
	localparam int MISS_GAP = 18;
	localparam int DRAIN = 40;
	localparam int TEST_CYCLES = LINES + FIO_OPS + LOADS + 2 * STORES + MIX_OPS
		+ SPACED_MISSES * (MISS_GAP + 1) + 4 + 20 + 9 + DRAIN;
	localparam int MAX_CYCLES = TEST_CYCLES + 100;  // room for reset and the pipeline tail.

	typedef struct packed {
		int                   due;
		gpu_mem_pkg::mem_wb_t value;
		logic                 chk_tags;
	} wb_exp_t;

	typedef struct packed {
		int           due;
		logic [255:0] data;
	} line_exp_t;

	typedef struct packed {
		int                    due;
		gpu_mem_pkg::mshr_fb_t value;
	} fb_exp_t;

	logic                    clk;
	logic                    resetb;
	gpu_mem_pkg::mem_req_t   req;
	gpu_mem_pkg::miss_info_t miss;
	gpu_mem_pkg::fio_req_t   fio;
	gpu_mem_pkg::mem_wb_t    wb;
	logic [255:0]            fio_rdata;
	gpu_mem_pkg::mshr_fb_t   fb;
	logic                    fio_check;  // the fill port result of this cycle is compared.

	logic [255:0] model_mem [LINES];
	fb_exp_t      mshr_q [$];  // outstanding misses in arrival order, due is the expiry cycle.
	wb_exp_t      wb_q [$];
	line_exp_t    fio_q [$];
	fb_exp_t      fb_q [$];
	int           cyc;
	int           errors;
	int           checks;
	bit           any_req;
	logic [`ADDR_W-1:0] line;
	logic [`ADDR_W-1:0] store_lines [STORES];

	clk_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(5)) i_clk_gen (.clk(clk), .resetb(resetb));

	mem_stage3 i_dut
	(
		.clk(clk),
		.resetb(resetb),
		.req_i(req),
		.miss_i(miss),
		.fio_i(fio),
		.wb_o(wb),
		.fio_rdata_o(fio_rdata),
		.fb_o(fb)
	);

	bind mem_stage3 mem_stage3_assertions i_assertions
	(
		.clk(clk),
		.resetb(resetb),
		.miss_i(miss_i),
		.wb_i(wb_o),
		.fb_i(fb_o)
	);

	function automatic logic [255:0] random_line();
		logic [255:0] l;
		for (int k = 0; k < `LANES; k++)
			l[k*32 +: 32] = $urandom();
		return l;
	endfunction

	function automatic gpu_mem_pkg::mem_tag_t random_tags();
		return gpu_mem_pkg::mem_tag_t'({$urandom(), $urandom(), 8'($urandom())});
	endfunction

	// expected write-back of a request, read from the line before this cycle's writes.
	function automatic gpu_mem_pkg::mem_wb_t predict_wb(gpu_mem_pkg::mem_req_t r);
		gpu_mem_pkg::mem_wb_t w;
		w = '0;
		w.reg_write = r.read;
		w.write_fb_valid = r.write;
		if (r.read)
			w.rdata = model_mem[r.addr[`ADDR_W-1:0]];
		if (r.read || r.write)
			w.tags = r.tags;
		return w;
	endfunction

	// one cycle of the miss table. Returns the feedback that shows up in the next cycle.
	function automatic gpu_mem_pkg::mshr_fb_t predict_fb(gpu_mem_pkg::miss_info_t m, int c);
		gpu_mem_pkg::mshr_fb_t f;
		fb_exp_t ent;
		int pick;
		int lat;
		bit full;
		f = '0;
		pick = -1;
		full = (mshr_q.size() == `MSHR_DEPTH);
		for (int i = mshr_q.size() - 1; i >= 0; i--)
			if (mshr_q[i].due <= c)
				pick = i;  // the lowest index is the oldest.
		if (pick >= 0)
		begin
			f = mshr_q[pick].value;
			mshr_q.delete(pick);
		end
		if (m.valid && !m.hit && !full)
		begin
			lat = (m.wait_flag || m.latency == '0) ? 1 : int'(m.latency);
			ent.due = c + lat;
			ent.value.valid = 1'b1;
			ent.value.addr = m.addr;
			ent.value.warp_id = m.warp_id;
			ent.value.scb_id = m.scb_id;
			mshr_q.push_back(ent);
		end
		return f;
	endfunction

	task automatic report_mismatch(string name, logic [255:0] expected, logic [255:0] actual);
		errors = errors + 1;
		$display("FAIL %s in cycle %0d: expected %h, got %h", name, cyc, expected, actual);
	endtask

	task automatic report_missing(string what);
		errors = errors + 1;
		$display("ERROR in cycle %0d: the expected %s did not appear", cyc, what);
	endtask

	task automatic finish_run();
		$display("summary: %0d errors over %0d checked cycles", errors, checks);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	// samples the inputs of the cycle that is ending and queues what they must produce.
	task automatic model_step();
		wb_exp_t   we;
		line_exp_t le;
		fb_exp_t   fe;
		logic [`ADDR_W-1:0] a;
		we.due = cyc + 2;
		we.value = predict_wb(req);
		we.chk_tags = req.read || req.write || !any_req;
		wb_q.push_back(we);
		if (req.read || req.write)
			any_req = 1'b1;
		if (fio_check)
		begin
			le.due = cyc + 1;
			le.data = model_mem[fio.addr];
			fio_q.push_back(le);
		end
		a = req.addr[`ADDR_W-1:0];
		for (int k = 0; k < `LANES; k++)
			if (req.write && req.wmask[k])
				model_mem[a][k*32 +: 32] = req.wdata[k*32 +: 32];
		if (fio.wen)
			model_mem[fio.addr] = fio.wdata;
		fe.value = predict_fb(miss, cyc);
		fe.due = cyc + 1;
		if (fe.value.valid)
			fb_q.push_back(fe);
	endtask

	task automatic check_reset_outputs();
		checks = checks + 1;
		if ({wb.reg_write, wb.write_fb_valid, fb.valid} !== 3'b000)
			report_mismatch("{reg_write,write_fb_valid,fb_o.valid}", '0,
				{wb.reg_write, wb.write_fb_valid, fb.valid});
		if (wb.rdata !== '0)
			report_mismatch("wb_o.rdata", '0, wb.rdata);
		if (wb.tags !== '0)
			report_mismatch("wb_o.tags", '0, wb.tags);
		if (fb !== '0)
			report_mismatch("fb_o", '0, fb);
		if (fio_rdata !== '0)
			report_mismatch("fio_rdata_o", '0, fio_rdata);
	endtask

	task automatic check_outputs();
		wb_exp_t   we;
		line_exp_t le;
		fb_exp_t   fe;
		checks = checks + 1;
		if (wb_q.size() != 0 && wb_q[0].due == cyc)
			we = wb_q.pop_front();
		else
		begin
			we.due = cyc;
			we.value = '0;  // the stage is still empty right after reset.
			we.chk_tags = 1'b1;
		end
		if (we.value.reg_write && wb.reg_write !== 1'b1)
			report_missing("load completion on wb_o.reg_write");
		else if (wb.reg_write !== we.value.reg_write)
			report_mismatch("wb_o.reg_write", we.value.reg_write, wb.reg_write);
		if (we.value.write_fb_valid && wb.write_fb_valid !== 1'b1)
			report_missing("store completion on wb_o.write_fb_valid");
		else if (wb.write_fb_valid !== we.value.write_fb_valid)
			report_mismatch("wb_o.write_fb_valid", we.value.write_fb_valid, wb.write_fb_valid);
		if (wb.rdata !== we.value.rdata)
			report_mismatch("wb_o.rdata", we.value.rdata, wb.rdata);
		if (we.chk_tags && wb.tags !== we.value.tags)
			report_mismatch("wb_o.tags", we.value.tags, wb.tags);
		if (fio_q.size() != 0 && fio_q[0].due == cyc)
		begin
			le = fio_q.pop_front();
			if (fio_rdata !== le.data)
				report_mismatch("fio_rdata_o", le.data, fio_rdata);
		end
		if (fb_q.size() != 0 && fb_q[0].due == cyc)
		begin
			fe = fb_q.pop_front();
			if (fb.valid !== 1'b1)
				report_missing("MSHR feedback pulse on fb_o");
			else if (fb !== fe.value)
				report_mismatch("fb_o", fe.value, fb);
		end
		else if (fb.valid !== 1'b0)
			report_mismatch("fb_o.valid", '0, fb.valid);
	endtask

	always @(posedge clk)
	begin
		if (!resetb)
		begin
			if (cyc > 0)
				check_reset_outputs();  // the outputs are only known to be reset after the first edge.
		end
		else
		begin
			check_outputs();
			model_step();
		end
		cyc = cyc + 1;
		if (cyc >= MAX_CYCLES)
		begin
			errors = errors + 1;
			$display("ERROR: the run did not finish within %0d cycles", MAX_CYCLES);
			finish_run();
		end
	end

	task automatic drive_idle();
		req = '0;
		miss = '0;
		fio.wen = 1'b0;
		fio_check = 1'b0;
	endtask

	task automatic idle_cycles(int n);
		repeat (n)
		begin
			@(negedge clk);
			drive_idle();
		end
	endtask

	task automatic send_fio(logic wen, logic [`ADDR_W-1:0] addr, logic check);
		@(negedge clk);
		drive_idle();
		fio.wen = wen;
		fio.addr = addr;
		fio.wdata = random_line();
		fio_check = check;
	endtask

	task automatic send_req(logic is_store, logic [`ADDR_W-1:0] addr);
		@(negedge clk);
		drive_idle();
		req.read = !is_store;
		req.write = is_store;
		req.addr = {18'($urandom()), addr};  // upper bits lie above the bank index.
		req.wdata = random_line();
		req.wmask = `LANES'($urandom());
		req.tags = random_tags();
	endtask

	task automatic send_miss(logic hit, logic wait_f, logic [`LAT_W-1:0] lat);
		@(negedge clk);
		drive_idle();
		miss.valid = 1'b1;
		miss.hit = hit;
		miss.wait_flag = wait_f;
		miss.latency = lat;
		miss.addr = 27'($urandom());
		miss.warp_id = 3'($urandom());
		miss.scb_id = 2'($urandom());
	endtask

	initial
	begin
		void'($urandom(65408));
		req = '0;
		miss = '0;
		fio = '0;
		fio_check = 1'b0;
		cyc = 0;
		errors = 0;
		checks = 0;
		any_req = 1'b0;
		@(posedge resetb);

		for (int i = 0; i < LINES; i++)
			send_fio(1'b1, `ADDR_W'(i), 1'b0);
		for (int i = 0; i < FIO_OPS; i++)
			send_fio(1'($urandom()), `ADDR_W'($urandom()), 1'b1);

		for (int i = 0; i < LOADS; i++)
			send_req(1'b0, `ADDR_W'($urandom()));

		for (int i = 0; i < STORES; i++)
		begin
			store_lines[i] = `ADDR_W'($urandom());
			send_req(1'b1, store_lines[i]);
		end
		for (int i = 0; i < STORES; i++)
			send_req(1'b0, store_lines[i]);

		// a kept line gives a store followed by a load to the same line.
		line = '0;
		for (int i = 0; i < MIX_OPS; i++)
		begin
			if ($urandom() % 4 != 0)
				line = `ADDR_W'($urandom());
			case ($urandom() % 4)
				0: idle_cycles(1);
				1: send_req(1'b1, line);
				default: send_req(1'b0, line);
			endcase
		end

		for (int i = 0; i < SPACED_MISSES; i++)
		begin
			send_miss(1'b0, (i == 2) || (i == 5), (i == 1) ? '0 : `LAT_W'(2 * i + 1));
			send_miss(1'b1, 1'b0, `LAT_W'($urandom()));
			idle_cycles(MISS_GAP - 1);
		end

		// these four all run out in the same cycle.
		for (int j = 0; j < 4; j++)
			send_miss(1'b0, 1'b0, `LAT_W'(8 - j));
		idle_cycles(20);

		repeat (9)
			send_miss(1'b0, 1'b0, '1);  // the ninth finds the table full.
		idle_cycles(DRAIN);

		if (fb_q.size() != 0 || mshr_q.size() != 0)
			report_missing("drain of all outstanding MSHR feedback by the end of the run");
		finish_run();
	end

endmodule

// File: mem_stage3.f
+incdir+rtl
rtl/gpu_mem_pkg.sv
rtl/dual_port_bram.sv
rtl/mshr_fifo.sv
rtl/mem_stage3.sv
bench/clk_gen.sv
bench/mem_stage3_assertions.sv
bench/mem_stage3_tb.sv

// File: rtl/dual_port_bram.sv
`timescale 1ns/1ps

module dual_port_bram
#(
	parameter int DATA_W = 32,
	parameter int ADDR_W = 9
)
(
	input  logic              clk,
	input  logic              a_wr_i,
	input  logic [ADDR_W-1:0] a_addr_i,
	input  logic [DATA_W-1:0] a_din_i,
	output logic [DATA_W-1:0] a_dout_o,
	input  logic              b_wr_i,
	input  logic [ADDR_W-1:0] b_addr_i,
	input  logic [DATA_W-1:0] b_din_i,
	output logic [DATA_W-1:0] b_dout_o
);
	localparam int DEPTH = 1 << ADDR_W;

	logic [DATA_W-1:0] mem [DEPTH];

	// both ports return the word as it was before this edge's write.
	always_ff @(posedge clk)
	begin
		a_dout_o <= mem[a_addr_i];
		b_dout_o <= mem[b_addr_i];
		if (a_wr_i)
			mem[a_addr_i] <= a_din_i;
		if (b_wr_i)
			mem[b_addr_i] <= b_din_i;
	end

endmodule

// File: rtl/gpu_mem_defines.svh
`ifndef GPU_MEM_DEFINES_SVH
`define GPU_MEM_DEFINES_SVH

// general memory words held in each lane bank.
`define MEM_SIZE 256

// shared-memory words, placed above the general words in the same bank.
`define SHMEM_SIZE 256

// index into a lane bank, wide enough for both regions.
`define ADDR_W ($clog2(`MEM_SIZE + `SHMEM_SIZE))

// outstanding misses the MSHR can track.
`define MSHR_DEPTH 8

// miss latency counter width.
`define LAT_W 5

// 32-bit lanes per cache line.
`define LANES 8

`endif

// File: rtl/gpu_mem_pkg.sv
`include "gpu_mem_defines.svh"

package gpu_mem_pkg;

	// bookkeeping that rides next to a load or store through the stage.
	typedef struct packed {
		logic [2:0]  warp_id;
		logic [1:0]  scb_id;
		logic [4:0]  reg_addr;
		logic [7:0]  thread_mask;
		logic [23:0] word_offset;
		logic [31:0] instr;
	} mem_tag_t;

	typedef struct packed {
		logic               read;   // load strobe.
		logic               write;  // store strobe.
		logic [26:0]        addr;
		logic [255:0]       wdata;
		logic [`LANES-1:0]  wmask;  // one enable per 32-bit lane.
		mem_tag_t           tags;
	} mem_req_t;

	typedef struct packed {
		logic         reg_write;       // load completion.
		logic         write_fb_valid;  // store completion.
		logic [255:0] rdata;
		mem_tag_t     tags;
	} mem_wb_t;

	// hit or miss status of the access, produced by the tag stage.
	typedef struct packed {
		logic              valid;
		logic              hit;
		logic              wait_flag;  // forces a latency of one.
		logic [`LAT_W-1:0] latency;
		logic [26:0]       addr;
		logic [2:0]        warp_id;
		logic [1:0]        scb_id;
	} miss_info_t;

	// negative feedback that tells the warp scheduler to replay a miss.
	typedef struct packed {
		logic        valid;
		logic [26:0] addr;
		logic [2:0]  warp_id;
		logic [1:0]  scb_id;
	} mshr_fb_t;

	typedef struct packed {
		logic               wen;
		logic [`ADDR_W-1:0] addr;
		logic [255:0]       wdata;
	} fio_req_t;

endpackage

// File: rtl/mem_stage3.sv
`timescale 1ns/1ps
`include "gpu_mem_defines.svh"

module mem_stage3
(
	input  logic                    clk,
	input  logic                    resetb,
	input  gpu_mem_pkg::mem_req_t   req_i,
	input  gpu_mem_pkg::miss_info_t miss_i,
	input  gpu_mem_pkg::fio_req_t   fio_i,
	output gpu_mem_pkg::mem_wb_t    wb_o,
	output logic [255:0]            fio_rdata_o,
	output gpu_mem_pkg::mshr_fb_t   fb_o
);
	localparam int WORD_W = 32;

	logic [`LANES-1:0]     lane_we;
	logic [255:0]          bank_rdata;
	logic [255:0]          fio_rdata_raw;
	logic                  fio_live_q;

	logic                  rd_q;
	logic                  wr_q;
	gpu_mem_pkg::mem_tag_t tags_q;

	// a store only touches the lanes selected by its mask.
	assign lane_we = {`LANES{req_i.write}} & req_i.wmask;

	generate
		for (genvar k = 0; k < `LANES; k++)
		begin : g_lane
			dual_port_bram
			#(
				.DATA_W(WORD_W),
				.ADDR_W(`ADDR_W)
			)
			i_bank
			(
				.clk(clk),
				.a_wr_i(lane_we[k]),
				.a_addr_i(req_i.addr[`ADDR_W-1:0]),
				.a_din_i(req_i.wdata[k*WORD_W +: WORD_W]),
				.a_dout_o(bank_rdata[k*WORD_W +: WORD_W]),
				.b_wr_i(fio_i.wen),
				.b_addr_i(fio_i.addr),
				.b_din_i(fio_i.wdata[k*WORD_W +: WORD_W]),
				.b_dout_o(fio_rdata_raw[k*WORD_W +: WORD_W])
			);
		end
	endgenerate

	mshr_fifo
	#(
		.DEPTH(`MSHR_DEPTH)
	)
	i_mshr
	(
		.clk(clk),
		.resetb(resetb),
		.miss_i(miss_i),
		.fb_o(fb_o)
	);

	// port B has produced a real read once a clock has passed since reset.
	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			fio_live_q <= 1'b0;
		else
			fio_live_q <= 1'b1;
	end

	assign fio_rdata_o = fio_live_q ? fio_rdata_raw : '0;

	// stage R lines up the strobes and tags with the bank read.
	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
			tags_q <= '0;
		end
		else
		begin
			rd_q <= req_i.read;
			wr_q <= req_i.write;
			tags_q <= req_i.tags;
		end
	end

	// stage W.
	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			wb_o <= '0;
		end
		else
		begin
			wb_o.reg_write <= rd_q;
			wb_o.write_fb_valid <= wr_q;
			wb_o.rdata <= rd_q ? bank_rdata : '0;  // no stale line leaks onto the bus.
			wb_o.tags <= tags_q;
		end
	end

endmodule

// File: rtl/mshr_fifo.sv
`timescale 1ns/1ps
`include "gpu_mem_defines.svh"

module mshr_fifo
#(
	parameter int DEPTH = `MSHR_DEPTH
)
(
	input  logic                    clk,
	input  logic                    resetb,
	input  gpu_mem_pkg::miss_info_t miss_i,
	output gpu_mem_pkg::mshr_fb_t   fb_o
);
	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [`LAT_W-1:0] LAT_ONE = 1;

	typedef struct packed {
		logic [26:0] addr;
		logic [2:0]  warp_id;
		logic [1:0]  scb_id;
	} entry_t;

	logic [DEPTH-1:0]  busy;
	logic [`LAT_W-1:0] count [DEPTH];
	logic [IDX_W-1:0]  age [DEPTH];  // number of busy entries older than this one.
	entry_t            entry [DEPTH];

	logic              alloc_req;
	logic              alloc;
	logic [`LAT_W-1:0] eff_lat;
	logic              free_found;
	logic [IDX_W-1:0]  free_idx;
	logic              exp_found;
	logic [IDX_W-1:0]  exp_idx;
	logic [CNT_W-1:0]  occupancy;
	logic [IDX_W-1:0]  new_age;

	assign alloc_req = miss_i.valid && !miss_i.hit;

	// a zero latency would never count down, so it is treated as one.
	assign eff_lat = (miss_i.wait_flag || miss_i.latency == '0) ? LAT_ONE : miss_i.latency;

	always_comb
	begin
		free_found = 1'b0;
		free_idx = '0;
		exp_found = 1'b0;
		exp_idx = '0;
		occupancy = '0;
		for (int i = 0; i < DEPTH; i++)
		begin
			if (busy[i])
				occupancy = occupancy + 1'b1;
			if (!busy[i] && !free_found)
			begin
				free_found = 1'b1;
				free_idx = IDX_W'(i);
			end
			// a count of one runs out on this edge, a count of zero is still queued.
			if (busy[i] && count[i] <= LAT_ONE && (!exp_found || age[i] < age[exp_idx]))
			begin
				exp_found = 1'b1;
				exp_idx = IDX_W'(i);
			end
		end
	end

	// a miss is dropped when every slot was occupied at the start of the cycle.
	assign alloc = alloc_req && free_found;

	// the newcomer is younger than everything that stays.
	assign new_age = IDX_W'(occupancy - CNT_W'(exp_found));

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			busy <= '0;
			fb_o <= '0;
			for (int i = 0; i < DEPTH; i++)
			begin
				count[i] <= '0;
				age[i] <= '0;
			end
		end
		else
		begin
			fb_o <= '0;
			if (exp_found)
			begin
				fb_o <= '{valid: 1'b1,
					addr: entry[exp_idx].addr,
					warp_id: entry[exp_idx].warp_id,
					scb_id: entry[exp_idx].scb_id};
				busy[exp_idx] <= 1'b0;
			end
			for (int i = 0; i < DEPTH; i++)
			begin
				if (busy[i] && count[i] != '0)
					count[i] <= count[i] - LAT_ONE;
				if (exp_found && busy[i] && age[i] > age[exp_idx])
					age[i] <= age[i] - 1'b1;  // close the gap left by the freed entry.
			end
			if (alloc)
			begin
				busy[free_idx] <= 1'b1;
				count[free_idx] <= eff_lat;
				age[free_idx] <= new_age;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc)
			entry[free_idx] <= '{addr: miss_i.addr,
				warp_id: miss_i.warp_id,
				scb_id: miss_i.scb_id};
	end

endmodule
